// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = tb_rv_core
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output.
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+logic
+incdir+bench
logic/bus_pkg.sv
logic/rv_pkg.sv
logic/mem_req_if.sv
logic/alu.sv
logic/reg_file.sv
logic/inst_decode.sv
logic/core_ctrl.sv
logic/bus_bridge.sv
logic/rv_core.sv
bench/tb_rv_core.sv

// ==== bench/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_words  = 43;
localparam int store_count = 17;

// Program at address 0, one word per instruction.
localparam logic [31:0] program_words [prog_words] = '{
  32'h0640_0093,  // 0x00 addi x1, x0, 100
  32'hff90_0113,  // 0x04 addi x2, x0, -7
  32'h0020_81b3,  // 0x08 add  x3, x1, x2
  32'h2000_0513,  // 0x0c addi x10, x0, 0x200
  32'h0035_2023,  // 0x10 sw   x3, 0(x10)
  32'h4020_8233,  // 0x14 sub  x4, x1, x2
  32'h0045_2223,  // 0x18 sw   x4, 4(x10)
  32'h0f01_7293,  // 0x1c andi x5, x2, 0xf0
  32'h0055_2423,  // 0x20 sw   x5, 8(x10)
  32'h7000_e313,  // 0x24 ori  x6, x1, 0x700
  32'h0065_2623,  // 0x28 sw   x6, 12(x10)
  32'hfff1_4393,  // 0x2c xori x7, x2, -1
  32'h0075_2823,  // 0x30 sw   x7, 16(x10)
  32'h0020_f433,  // 0x34 and  x8, x1, x2
  32'h0020_e4b3,  // 0x38 or   x9, x1, x2
  32'h0094_45b3,  // 0x3c xor  x11, x8, x9
  32'h0085_2a23,  // 0x40 sw   x8, 20(x10)
  32'h0095_2c23,  // 0x44 sw   x9, 24(x10)
  32'h00b5_2e23,  // 0x48 sw   x11, 28(x10)
  32'h1234_5637,  // 0x4c lui  x12, 0x12345
  32'h02c5_2023,  // 0x50 sw   x12, 32(x10)
  32'h0011_26b3,  // 0x54 slt  x13, x2, x1
  32'h0020_a733,  // 0x58 slt  x14, x1, x2
  32'h02d5_2223,  // 0x5c sw   x13, 36(x10)
  32'h02e5_2423,  // 0x60 sw   x14, 40(x10)
  32'h0005_2783,  // 0x64 lw   x15, 0(x10)
  32'h02f5_2623,  // 0x68 sw   x15, 44(x10)
  32'h1000_2803,  // 0x6c lw   x16, 0x100(x0)
  32'h0305_2823,  // 0x70 sw   x16, 48(x10)
  32'h0010_8463,  // 0x74 beq  x1, x1, +8
  32'h0215_2a23,  // 0x78 sw   x1, 52(x10)   skipped
  32'h0020_8463,  // 0x7c beq  x1, x2, +8
  32'h0215_2c23,  // 0x80 sw   x1, 56(x10)
  32'h0020_9463,  // 0x84 bne  x1, x2, +8
  32'h0225_2e23,  // 0x88 sw   x2, 60(x10)   skipped
  32'h0010_9463,  // 0x8c bne  x1, x1, +8
  32'h0425_2023,  // 0x90 sw   x2, 64(x10)
  32'h0080_08ef,  // 0x94 jal  x17, +8
  32'h0515_2223,  // 0x98 sw   x17, 68(x10)  skipped
  32'h0515_2423,  // 0x9c sw   x17, 72(x10)
  32'h0050_8013,  // 0xa0 addi x0, x1, 5
  32'h0405_2623,  // 0xa4 sw   x0, 76(x10)
  32'h0000_006f   // 0xa8 jal  x0, 0
};

// Word read back by the second load.
localparam logic [31:0] preload_addr = 32'h0000_0100;
localparam logic [31:0] preload_data = 32'hcafe_f00d;

// Expected stores in order, address then data.
localparam logic [63:0] expected_stores [store_count] = '{
  {32'h0000_0200, 32'h0000_005d},
  {32'h0000_0204, 32'h0000_006b},
  {32'h0000_0208, 32'h0000_00f0},
  {32'h0000_020c, 32'h0000_0764},
  {32'h0000_0210, 32'h0000_0006},
  {32'h0000_0214, 32'h0000_0060},
  {32'h0000_0218, 32'hffff_fffd},
  {32'h0000_021c, 32'hffff_ff9d},
  {32'h0000_0220, 32'h1234_5000},
  {32'h0000_0224, 32'h0000_0001},
  {32'h0000_0228, 32'h0000_0000},
  {32'h0000_022c, 32'h0000_005d},
  {32'h0000_0230, 32'hcafe_f00d},
  {32'h0000_0238, 32'h0000_0064},
  {32'h0000_0240, 32'hffff_fff9},
  {32'h0000_0248, 32'h0000_0098},
  {32'h0000_024c, 32'h0000_0000}
};

`endif

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_rv_core;

  `include "tb_program.svh"

  localparam int mem_words  = 256;
  localparam int wait_limit = 100;

  logic        clock;
  logic        reset;
  logic        io_master_awready;
  logic        io_master_awvalid;
  logic [31:0] io_master_awaddr;
  logic        io_master_wready;
  logic        io_master_wvalid;
  logic [31:0] io_master_wdata;
  logic [3:0]  io_master_wstrb;
  logic        io_master_bready;
  logic        io_master_bvalid;
  logic        io_master_arready;
  logic        io_master_arvalid;
  logic [31:0] io_master_araddr;
  logic        io_master_rready;
  logic        io_master_rvalid;
  logic [31:0] io_master_rdata;

  logic [31:0] mem [mem_words];
  logic [31:0] lfsr;
  int          errors;
  int          stores_seen;
  int          reads;
  bit          timed_out;

  rv_core uut (
    .clock             (clock),
    .reset             (reset),
    .io_master_awready (io_master_awready),
    .io_master_awvalid (io_master_awvalid),
    .io_master_awaddr  (io_master_awaddr),
    .io_master_wready  (io_master_wready),
    .io_master_wvalid  (io_master_wvalid),
    .io_master_wdata   (io_master_wdata),
    .io_master_wstrb   (io_master_wstrb),
    .io_master_bready  (io_master_bready),
    .io_master_bvalid  (io_master_bvalid),
    .io_master_arready (io_master_arready),
    .io_master_arvalid (io_master_arvalid),
    .io_master_araddr  (io_master_araddr),
    .io_master_rready  (io_master_rready),
    .io_master_rvalid  (io_master_rvalid),
    .io_master_rdata   (io_master_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ##############################
  // Stall generator.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic pick_delay(output int cycles);
    logic [1:0] bits;
    for (int n = 0; n < 2; n++) begin
      bits[n] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
    cycles = int'(bits);
  endtask

  function automatic bit in_memory(input logic [31:0] addr);
    return addr < 32'(4 * mem_words) && addr[1:0] == 2'b00;
  endfunction

  // ##############################
  // AXI memory model.
  task automatic wait_response(input bit is_read);
    int count;
    count = 0;
    while (!(is_read ? io_master_rready : io_master_bready) && count < wait_limit) begin
      @(negedge clock);
      count++;
    end
    if (!(is_read ? io_master_rready : io_master_bready)) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: the core never became ready for the %s response",
               is_read ? "read" : "write");
    end
  endtask

  task automatic give_response(input bit is_read, input logic [31:0] data);
    int delay;
    pick_delay(delay);
    repeat (delay) begin
      @(negedge clock);
      if (!(is_read ? io_master_rready : io_master_bready)) begin
        errors++;
        $display("Response ready dropped before the response was given");
      end
    end
    if (is_read) begin
      io_master_rdata  = data;
      io_master_rvalid = 1'b1;
    end else begin
      io_master_bvalid = 1'b1;
    end
    @(negedge clock);
    io_master_rvalid = 1'b0;
    io_master_bvalid = 1'b0;
  endtask

  task automatic serve_read();
    logic [31:0] addr;
    logic [31:0] data;
    int          delay;
    addr = io_master_araddr;
    if (reads == 0 && addr != `RESET_PC) begin
      errors++;
      $display("Mismatch io_master_araddr: got 0x%08h expected 0x%08h", addr, `RESET_PC);
    end
    reads++;
    pick_delay(delay);
    repeat (delay) begin
      @(negedge clock);
      if (!io_master_arvalid || io_master_araddr != addr) begin
        errors++;
        $display("Mismatch io_master_araddr under stall: got 0x%08h expected 0x%08h",
                 io_master_araddr, addr);
      end
    end
    io_master_arready = 1'b1;
    @(negedge clock);
    io_master_arready = 1'b0;
    wait_response(1'b1);
    if (timed_out) begin
      return;
    end
    data = 32'h0;
    if (in_memory(addr)) begin
      data = mem[addr[9:2]];
    end else begin
      errors++;
      $display("Read outside the memory model at 0x%08h", addr);
    end
    give_response(1'b1, data);
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    {exp_addr, exp_data} = expected_stores[stores_seen];
    if (addr != exp_addr) begin
      errors++;
      $display("Mismatch io_master_awaddr (store %0d): got 0x%08h expected 0x%08h",
               stores_seen, addr, exp_addr);
    end
    if (data != exp_data) begin
      errors++;
      $display("Mismatch io_master_wdata (store %0d): got 0x%08h expected 0x%08h",
               stores_seen, data, exp_data);
    end
    stores_seen++;
    if (in_memory(addr)) begin
      mem[addr[9:2]] = data;
    end else begin
      errors++;
      $display("Write outside the memory model at 0x%08h", addr);
    end
  endtask

  task automatic serve_write();
    logic [31:0] addr;
    logic [31:0] data;
    int          aw_delay;
    int          w_delay;
    bit          aw_taken;
    bit          w_taken;
    addr = io_master_awaddr;
    data = io_master_wdata;
    if (io_master_wstrb != 4'hf) begin
      errors++;
      $display("Mismatch io_master_wstrb: got 0x%h expected 0xf", io_master_wstrb);
    end
    pick_delay(aw_delay);
    pick_delay(w_delay);
    aw_taken = 1'b0;
    w_taken  = 1'b0;
    // Bounded by the two stalls, at most four cycles.
    while (!(aw_taken && w_taken)) begin
      io_master_awready = 1'b0;
      io_master_wready  = 1'b0;
      if (!aw_taken) begin
        if (!io_master_awvalid || io_master_awaddr != addr) begin
          errors++;
          $display("Mismatch io_master_awaddr under stall: got 0x%08h expected 0x%08h",
                   io_master_awaddr, addr);
        end
        if (aw_delay == 0) begin
          io_master_awready = 1'b1;
          aw_taken          = 1'b1;
        end else begin
          aw_delay--;
        end
      end
      if (!w_taken) begin
        if (!io_master_wvalid || io_master_wdata != data) begin
          errors++;
          $display("Mismatch io_master_wdata under stall: got 0x%08h expected 0x%08h",
                   io_master_wdata, data);
        end
        if (w_delay == 0) begin
          io_master_wready = 1'b1;
          w_taken          = 1'b1;
        end else begin
          w_delay--;
        end
      end
      @(negedge clock);
    end
    io_master_awready = 1'b0;
    io_master_wready  = 1'b0;
    wait_response(1'b0);
    if (timed_out) begin
      return;
    end
    give_response(1'b0, 32'h0);
    check_store(addr, data);
  endtask

  // ##############################
  // Main sequence.
  initial begin
    int count;
    reset             = 1'b1;
    io_master_awready = 1'b0;
    io_master_wready  = 1'b0;
    io_master_bvalid  = 1'b0;
    io_master_arready = 1'b0;
    io_master_rvalid  = 1'b0;
    io_master_rdata   = 32'h0;
    lfsr              = 32'ha5c4_c66b;
    errors            = 0;
    stores_seen       = 0;
    reads             = 0;
    timed_out         = 1'b0;
    for (int n = 0; n < mem_words; n++) begin
      mem[n] = 32'h5a5a_0000 | 32'(n);
    end
    for (int n = 0; n < prog_words; n++) begin
      mem[n] = program_words[n];
    end
    mem[preload_addr[9:2]] = preload_data;

    repeat (8) @(negedge clock);
    if (io_master_arvalid || io_master_awvalid || io_master_wvalid) begin
      errors++;
      $display("A bus valid was high during reset");
    end
    reset = 1'b0;

    count = 0;
    while (!io_master_arvalid && count < 2) begin
      @(negedge clock);
      count++;
    end
    if (!io_master_arvalid) begin
      errors++;
      $display("The first read address did not appear within 2 cycles of reset");
    end

    while (stores_seen < store_count && !timed_out) begin
      count = 0;
      while (!(io_master_arvalid || io_master_awvalid || io_master_wvalid) &&
             count < wait_limit) begin
        @(negedge clock);
        count++;
      end
      if (io_master_arvalid) begin
        serve_read();
      end else if (io_master_awvalid || io_master_wvalid) begin
        serve_write();
      end else begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: no bus request for %0d cycles", wait_limit);
      end
    end

    $display("Errors: %0d, stores checked: %0d of %0d, reads served: %0d",
             errors, stores_seen, store_count, reads);
    if (errors != 0) begin
      $display("SIMULATION FAILED");
    end else begin
      $display("SIMULATION PASSED");
    end
    $finish;
  end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu import rv_pkg::*; (
  input  alu_op_e          op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result,
  output logic             equal
);

  logic less;

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ADD:     result = a + b;
      SUB:     result = a - b;
      AND:     result = a & b;
      OR:      result = a | b;
      XOR:     result = a ^ b;
      SLT:     result = {{(`XLEN-1){1'b0}}, less};
      // LUI passes the shifted immediate.
      PASS_B:  result = b;
      default: result = a + b;
    endcase
  end

  // Branch compare.
  assign equal = (a == b);

endmodule

// ==== logic/bus_bridge.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module bus_bridge import bus_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  mem_req_if.responder     fetch_bus,
  mem_req_if.responder     data_bus,
  input  logic             awready,
  output logic             awvalid,
  output logic [`XLEN-1:0] awaddr,
  input  logic             wready,
  output logic             wvalid,
  output logic [`XLEN-1:0] wdata,
  output strb_t            wstrb,
  output logic             bready,
  input  logic             bvalid,
  input  logic             arready,
  output logic             arvalid,
  output logic [`XLEN-1:0] araddr,
  output logic             rready,
  input  logic             rvalid,
  input  logic [`XLEN-1:0] rdata
);

  bridge_state_e    state;
  logic             sel_data;
  req_kind_e        kind_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] wdata_q;
  logic [`XLEN-1:0] rdata_q;
  logic             aw_done;
  logic             w_done;
  logic             is_write;
  logic             aw_ok;
  logic             w_ok;

  assign is_write = (kind_q == WRITE);
  assign aw_ok    = aw_done || (awvalid && awready);
  assign w_ok     = w_done || (wvalid && wready);

  // ##############################
  // Requester side. Data wins a tie.
  assign data_bus.ready  = (state == IDLE);
  assign fetch_bus.ready = (state == IDLE) && !data_bus.valid;
  assign data_bus.rdata  = rdata_q;
  assign fetch_bus.rdata = rdata_q;
  assign data_bus.done   = (state == DONE) && sel_data;
  assign fetch_bus.done  = (state == DONE) && !sel_data;

  // ##############################
  // AXI side.
  assign arvalid = (state == ADDR) && !is_write;
  assign awvalid = (state == ADDR) && is_write && !aw_done;
  assign wvalid  = (state == ADDR) && is_write && !w_done;
  assign araddr  = addr_q;
  assign awaddr  = addr_q;
  assign wdata   = wdata_q;
  assign wstrb   = STRB_FULL;
  assign rready  = (state == RESP) && !is_write;
  assign bready  = (state == RESP) && is_write;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      unique case (state)
        IDLE: if (data_bus.valid || fetch_bus.valid) state <= ADDR;
        ADDR: begin
          if (!is_write) begin
            if (arready) state <= RESP;
          end else if (aw_ok && w_ok) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= RESP;
          end else begin
            aw_done <= aw_ok;
            w_done  <= w_ok;
          end
        end
        RESP: if (is_write ? bvalid : rvalid) state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  // Request captured on acceptance, read data on arrival.
  always_ff @(posedge clock) begin
    if (state == IDLE) begin
      sel_data <= data_bus.valid;
      kind_q   <= data_bus.valid ? data_bus.kind : fetch_bus.kind;
      addr_q   <= data_bus.valid ? data_bus.addr : fetch_bus.addr;
      wdata_q  <= data_bus.valid ? data_bus.wdata : fetch_bus.wdata;
    end
    if (rready && rvalid) begin
      rdata_q <= rdata;
    end
  end

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr));
  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr));
  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

// ==== logic/bus_pkg.sv ====
`include "core_cfg.svh"

package bus_pkg;

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } req_kind_e;

  typedef logic [`XLEN/8-1:0] strb_t;

  // Only whole words move on the bus.
  localparam strb_t STRB_FULL = '1;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ADDR = 2'd1,
    RESP = 2'd2,
    DONE = 2'd3
  } bridge_state_e;

endpackage

// ==== logic/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and address width.
`define XLEN 32

// Architectural register count.
`define NUM_REGS 32

// First fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== logic/core_ctrl.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_ctrl import rv_pkg::*, bus_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  ctrl_t            ctrl,
  input  logic [`XLEN-1:0] imm,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] alu_result,
  input  logic             alu_equal,
  output inst_t            inst,
  output logic [`XLEN-1:0] alu_a,
  output logic [`XLEN-1:0] alu_b,
  output logic             rd_write,
  output logic [`XLEN-1:0] rd_data,
  mem_req_if.requester     fetch_bus,
  mem_req_if.requester     data_bus
);

  typedef enum logic [2:0] {
    FETCH     = 3'd0,
    DECODE    = 3'd1,
    EXECUTE   = 3'd2,
    MEM       = 3'd3,
    WRITEBACK = 3'd4
  } state_e;

  state_e           state;
  logic [`XLEN-1:0] pc;
  logic             req_sent;
  inst_t            inst_q;
  logic [`XLEN-1:0] rs1_q;
  logic [`XLEN-1:0] rs2_q;
  logic [`XLEN-1:0] result_q;
  logic             taken_q;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] next_pc;

  // ##############################
  // Memory requests.
  assign fetch_bus.valid = (state == FETCH) && !req_sent;
  assign fetch_bus.kind  = READ;
  assign fetch_bus.addr  = pc;
  assign fetch_bus.wdata = '0;

  assign data_bus.valid = (state == MEM) && !req_sent;
  assign data_bus.kind  = ctrl.mem_write ? WRITE : READ;
  assign data_bus.addr  = result_q;
  assign data_bus.wdata = rs2_q;

  // ##############################
  // Datapath outputs.
  assign inst  = inst_q;
  assign alu_a = rs1_q;
  assign alu_b = ctrl.src_b_imm ? imm : rs2_q;

  assign link    = pc + 32'd4;
  assign next_pc = (ctrl.jump || taken_q) ? pc + imm : link;

  assign rd_write = (state == WRITEBACK) && ctrl.reg_write;
  assign rd_data  = ctrl.jump ? link : result_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= FETCH;
      pc       <= `RESET_PC;
      req_sent <= 1'b0;
    end else begin
      unique case (state)
        FETCH: begin
          if (fetch_bus.valid && fetch_bus.ready) begin
            req_sent <= 1'b1;
          end
          if (fetch_bus.done) begin
            req_sent <= 1'b0;
            state    <= DECODE;
          end
        end
        DECODE: state <= EXECUTE;
        EXECUTE: state <= (ctrl.mem_read || ctrl.mem_write) ? MEM : WRITEBACK;
        MEM: begin
          if (data_bus.valid && data_bus.ready) begin
            req_sent <= 1'b1;
          end
          if (data_bus.done) begin
            req_sent <= 1'b0;
            state    <= WRITEBACK;
          end
        end
        default: begin
          pc    <= next_pc;
          state <= FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH && fetch_bus.done) begin
      inst_q <= fetch_bus.rdata;
    end
    if (state == DECODE) begin
      rs1_q <= rs1_data;
      rs2_q <= rs2_data;
    end
    if (state == EXECUTE) begin
      result_q <= alu_result;
      taken_q  <= ctrl.branch && (alu_equal != ctrl.branch_ne);
    end
    if (state == MEM && data_bus.done && ctrl.mem_read) begin
      result_q <= data_bus.rdata;
    end
  end

  // Branch and jump targets keep fetches word aligned.
  pc_aligned: assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module inst_decode import rv_pkg::*; (
  input  inst_t            inst,
  output ctrl_t            ctrl,
  output logic [`XLEN-1:0] imm,
  output logic [4:0]       rs1,
  output logic [4:0]       rs2,
  output logic [4:0]       rd
);

  // Register and immediate arithmetic share funct3.
  function automatic logic arith_ok(input logic [2:0] funct3);
    return funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
  endfunction

  function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic sub);
    case (funct3)
      3'b010:  return SLT;
      3'b100:  return XOR;
      3'b110:  return OR;
      3'b111:  return AND;
      default: return sub ? SUB : ADD;
    endcase
  endfunction

  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;
  assign rd  = inst.r.rd;

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (inst.r.opcode)
      OP: begin
        ctrl.alu_op    = arith_op(inst.r.funct3, inst.r.funct7[5]);
        ctrl.reg_write = arith_ok(inst.r.funct3);
      end
      OP_IMM: begin
        imm            = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        ctrl.alu_op    = arith_op(inst.i.funct3, 1'b0);
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_write = arith_ok(inst.i.funct3);
      end
      LUI: begin
        imm            = {inst.u.imm_31_12, 12'b0};
        ctrl.alu_op    = PASS_B;
        ctrl.src_b_imm = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      BRANCH: begin
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
        // BEQ and BNE only.
        ctrl.branch    = (inst.b.funct3[2:1] == 2'b00);
        ctrl.branch_ne = inst.b.funct3[0];
        ctrl.alu_op    = SUB;
      end
      JAL: begin
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      LOAD: begin
        imm            = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
        ctrl.src_b_imm = 1'b1;
        ctrl.mem_read  = (inst.i.funct3 == 3'b010);
        ctrl.reg_write = (inst.i.funct3 == 3'b010);
      end
      STORE: begin
        imm            = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
        ctrl.src_b_imm = 1'b1;
        ctrl.mem_write = (inst.s.funct3 == 3'b010);
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/mem_req_if.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

interface mem_req_if import bus_pkg::*; ();

  logic             valid;
  logic             ready;
  req_kind_e        kind;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] wdata;
  logic [`XLEN-1:0] rdata;
  // One cycle pulse, rdata valid with it.
  logic             done;

  modport requester (output valid, kind, addr, wdata, input ready, rdata, done);
  modport responder (input valid, kind, addr, wdata, output ready, rdata, done);

endinterface

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [$clog2(`NUM_REGS)-1:0] rs1,
  input  logic [$clog2(`NUM_REGS)-1:0] rs2,
  input  logic [$clog2(`NUM_REGS)-1:0] rd,
  input  logic                         write,
  input  logic [`XLEN-1:0]             wdata,
  output logic [`XLEN-1:0]             rs1_data,
  output logic [`XLEN-1:0]             rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 0; n < `NUM_REGS; n++) begin
        regs[n] <= '0;
      end
    end else if (write && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // x0 stays zero whatever the writeback asks for.
  x0_zero: assert property (@(posedge clock) disable iff (reset)
    write && rd == '0 |=> regs[0] == '0);

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`include "core_cfg.svh"

module rv_core import rv_pkg::*, bus_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             io_master_awready,
  output logic             io_master_awvalid,
  output logic [`XLEN-1:0] io_master_awaddr,
  input  logic             io_master_wready,
  output logic             io_master_wvalid,
  output logic [`XLEN-1:0] io_master_wdata,
  output strb_t            io_master_wstrb,
  output logic             io_master_bready,
  input  logic             io_master_bvalid,
  input  logic             io_master_arready,
  output logic             io_master_arvalid,
  output logic [`XLEN-1:0] io_master_araddr,
  output logic             io_master_rready,
  input  logic             io_master_rvalid,
  input  logic [`XLEN-1:0] io_master_rdata
);

  inst_t            inst;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] imm;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [4:0]       rd;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic             alu_equal;
  logic             rd_write;
  logic [`XLEN-1:0] rd_data;

  mem_req_if fetch_bus ();
  mem_req_if data_bus ();

  // ##############################
  // Control and datapath.
  core_ctrl ctrl_u (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .alu_equal  (alu_equal),
    .inst       (inst),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .rd_write   (rd_write),
    .rd_data    (rd_data),
    .fetch_bus  (fetch_bus.requester),
    .data_bus   (data_bus.requester)
  );

  inst_decode decode_u (
    .inst (inst),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  alu alu_u (
    .op     (ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .equal  (alu_equal)
  );

  reg_file rf_u (
    .clock    (clock),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .write    (rd_write),
    .wdata    (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ##############################
  // Single master port.
  bus_bridge bridge_u (
    .clock     (clock),
    .reset     (reset),
    .fetch_bus (fetch_bus.responder),
    .data_bus  (data_bus.responder),
    .awready   (io_master_awready),
    .awvalid   (io_master_awvalid),
    .awaddr    (io_master_awaddr),
    .wready    (io_master_wready),
    .wvalid    (io_master_wvalid),
    .wdata     (io_master_wdata),
    .wstrb     (io_master_wstrb),
    .bready    (io_master_bready),
    .bvalid    (io_master_bvalid),
    .arready   (io_master_arready),
    .arvalid   (io_master_arvalid),
    .araddr    (io_master_araddr),
    .rready    (io_master_rready),
    .rvalid    (io_master_rvalid),
    .rdata     (io_master_rdata)
  );

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

  // Major opcodes of the supported subset.
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    AND    = 4'd2,
    OR     = 4'd3,
    XOR    = 4'd4,
    SLT    = 4'd5,
    PASS_B = 4'd6
  } alu_op_e;

  // ##############################
  // Instruction formats.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // One fetched word, seen through each format.
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } inst_t;

  typedef struct packed {
    alu_op_e alu_op;
    logic    src_b_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;
    logic    jump;
  } ctrl_t;

endpackage
